//--- hw/activity_leds.sv
// activity leds, each flips on the rising edge of its event
`timescale 1ns/1ps

module activity_leds (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       demod_is_ongoing_i,
  input  logic       pkt_header_valid_i,
  input  logic       pkt_header_valid_strobe_i,
  input  logic       phy_tx_started_i,
  output logic [2:0] leds_o
);

  logic       sig_valid;
  logic [2:0] ev;
  logic [2:0] ev_q;

  assign sig_valid = pkt_header_valid_strobe_i & pkt_header_valid_i; // good SIG only
  assign ev = {phy_tx_started_i, sig_valid, demod_is_ongoing_i};

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ev_q   <= '0;
      leds_o <= '0;
    end else begin
      ev_q   <= ev;
      leds_o <= leds_o ^ (ev & ~ev_q); // toggle on rising edge
    end
  end

endmodule

//--- hw/rx_header_parse.sv
// received mac header parser for fc and duration, addr1-3, seq ctrl and the packet-for-me flag
`timescale 1ns/1ps

module rx_header_parse import xpu_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  rx_byte_t                  rx_byte_i,
  input  logic                      pkt_header_valid_strobe_i,
  input  logic [MAC_ADDR_WIDTH-1:0] mac_addr_i,
  output rx_hdr_t                   rx_hdr_o,
  output logic                      pkt_for_me_o
);

  logic [15:0]               idx;
  logic [7:0]                din;
  logic [4:0]                in_field;  // fc, addr1, addr2, addr3, sc
  logic [4:0]                last_hit;
  logic [MAC_ADDR_WIDTH-1:0] addr1_next;

  fc_di_u                    fc_q;
  logic [MAC_ADDR_WIDTH-1:0] addr1_q;
  logic [MAC_ADDR_WIDTH-1:0] addr2_q;
  logic [MAC_ADDR_WIDTH-1:0] addr3_q;
  logic [15:0]               sc_q;
  logic [4:0]                valid_q;
  logic                      for_me_q;

  assign idx = rx_byte_i.idx;
  assign din = rx_byte_i.data;

  // field select by byte index
  always_comb begin
    in_field[0] = (idx >= HDR_FC_OFS)    && (idx < HDR_ADDR1_OFS);
    in_field[1] = (idx >= HDR_ADDR1_OFS) && (idx < HDR_ADDR2_OFS);
    in_field[2] = (idx >= HDR_ADDR2_OFS) && (idx < HDR_ADDR3_OFS);
    in_field[3] = (idx >= HDR_ADDR3_OFS) && (idx < HDR_SC_OFS);
    in_field[4] = (idx >= HDR_SC_OFS)    && (idx < HDR_LEN);
    in_field    = in_field & {5{rx_byte_i.strobe}};

    last_hit[0] = (idx == HDR_ADDR1_OFS - 1);
    last_hit[1] = (idx == HDR_ADDR2_OFS - 1);
    last_hit[2] = (idx == HDR_ADDR3_OFS - 1);
    last_hit[3] = (idx == HDR_SC_OFS - 1);
    last_hit[4] = (idx == HDR_LEN - 1);
    last_hit    = last_hit & {5{rx_byte_i.strobe}};
  end

  // first byte on air is the low byte, so shift in from the top
  assign addr1_next = {din, addr1_q[MAC_ADDR_WIDTH-1:8]};

  always_ff @(posedge clk) begin
    if (in_field[0]) fc_q.raw <= {din, fc_q.raw[31:8]};
    if (in_field[1]) addr1_q  <= addr1_next;
    if (in_field[2]) addr2_q  <= {din, addr2_q[MAC_ADDR_WIDTH-1:8]};
    if (in_field[3]) addr3_q  <= {din, addr3_q[MAC_ADDR_WIDTH-1:8]};
    if (in_field[4]) sc_q     <= {din, sc_q[15:8]};
  end

  // header strobe ends the frame and clears all flags
  always_ff @(posedge clk) begin
    if (!rst_n_i || pkt_header_valid_strobe_i) begin
      valid_q  <= '0;
      for_me_q <= 1'b0;
    end else begin
      valid_q <= valid_q | last_hit;
      if (last_hit[1]) begin
        for_me_q <= (addr1_next == mac_addr_i); // lands with addr1_valid
      end
    end
  end

  assign rx_hdr_o = '{fc:          fc_q,
                      addr1:       addr1_q,
                      addr2:       addr2_q,
                      addr3:       addr3_q,
                      sc:          sc_q,
                      fc_valid:    valid_q[0],
                      addr1_valid: valid_q[1],
                      addr2_valid: valid_q[2],
                      addr3_valid: valid_q[3],
                      sc_valid:    valid_q[4]};

  assign pkt_for_me_o = for_me_q;

endmodule

//--- hw/tsf_timer.sv
// 802.11 tsf timer, 64 bit microsecond count with 1 us pulse and software load
`timescale 1ns/1ps

module tsf_timer import xpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  tsf_load_t                  tsf_load_i,
  output logic [TSF_TIMER_WIDTH-1:0] tsf_runtime_val_o,
  output logic                       tsf_pulse_1m_o
);

  logic [TSF_DIV_WIDTH-1:0]   div_cnt_q;
  logic [TSF_TIMER_WIDTH-1:0] tsf_q;
  logic                       pulse_q;
  logic                       us_tick;

  assign us_tick = (div_cnt_q == TSF_DIV_WIDTH'(TSF_CLKS_PER_US - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      div_cnt_q <= '0;
      tsf_q     <= '0;
      pulse_q   <= 1'b0;
    end else if (tsf_load_i.load) begin
      // new time base, divider starts over
      div_cnt_q <= '0;
      tsf_q     <= tsf_load_i.val;
      pulse_q   <= 1'b0;
    end else begin
      pulse_q <= us_tick;
      if (us_tick) begin
        div_cnt_q <= '0;
        tsf_q     <= tsf_q + TSF_TIMER_WIDTH'(1); // steps with the pulse edge
      end else begin
        div_cnt_q <= div_cnt_q + TSF_DIV_WIDTH'(1);
      end
    end
  end

  assign tsf_runtime_val_o = tsf_q;
  assign tsf_pulse_1m_o    = pulse_q;

endmodule

//--- hw/xpu.sv
// xpu top wiring the registers, tsf timer, rx header parser and activity leds
`timescale 1ns/1ps

module xpu import xpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n_i,

  // register access
  input  reg_wr_t                    reg_wr_i,
  input  logic                       rd_en_i,
  input  logic [REG_ADDR_WIDTH-1:0]  rd_addr_i,
  output logic [REG_DATA_WIDTH-1:0]  rd_data_o,
  output logic                       rd_valid_o,

  // from demodulator
  input  rx_byte_t                   rx_byte_i,
  input  logic                       pkt_header_valid_i,
  input  logic                       pkt_header_valid_strobe_i,
  input  logic                       demod_is_ongoing_i,
  input  logic                       phy_tx_started_i,

  output rx_hdr_t                    rx_hdr_o,
  output logic                       pkt_for_me_o,
  output logic [TSF_TIMER_WIDTH-1:0] tsf_runtime_val_o,
  output logic                       tsf_pulse_1m_o,
  output logic [3:0]                 band_o,
  output logic [15:0]                channel_o,
  output logic [MAC_ADDR_WIDTH-1:0]  mac_addr_o,
  output logic [2:0]                 leds_o
);

  tsf_load_t tsf_load;

  xpu_regs xpu_regs_i (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .reg_wr_i          (reg_wr_i),
    .rd_en_i           (rd_en_i),
    .rd_addr_i         (rd_addr_i),
    .tsf_runtime_val_i (tsf_runtime_val_o),
    .rx_hdr_i          (rx_hdr_o),          // addr2 read-back
    .rd_data_o         (rd_data_o),
    .rd_valid_o        (rd_valid_o),
    .tsf_load_o        (tsf_load),
    .band_o            (band_o),
    .channel_o         (channel_o),
    .mac_addr_o        (mac_addr_o)
  );

  tsf_timer tsf_timer_i (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .tsf_load_i        (tsf_load),
    .tsf_runtime_val_o (tsf_runtime_val_o),
    .tsf_pulse_1m_o    (tsf_pulse_1m_o)
  );

  rx_header_parse rx_header_parse_i (
    .clk                       (clk),
    .rst_n_i                   (rst_n_i),
    .rx_byte_i                 (rx_byte_i),
    .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
    .mac_addr_i                (mac_addr_o), // own station address
    .rx_hdr_o                  (rx_hdr_o),
    .pkt_for_me_o              (pkt_for_me_o)
  );

  activity_leds activity_leds_i (
    .clk                       (clk),
    .rst_n_i                   (rst_n_i),
    .demod_is_ongoing_i        (demod_is_ongoing_i),
    .pkt_header_valid_i        (pkt_header_valid_i),
    .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
    .phy_tx_started_i          (phy_tx_started_i),
    .leds_o                    (leds_o)
  );

endmodule

//--- hw/xpu_pkg.sv
// xpu housekeeping package with register map, widths, tsf divider and rx header types
package xpu_pkg;

  localparam int TSF_TIMER_WIDTH = 64; // 802.11 tsf is 64 bit
  localparam int REG_DATA_WIDTH  = 32;
  localparam int REG_ADDR_WIDTH  = 6;  // word index, 64 regs
  localparam int MAC_ADDR_WIDTH  = 48;
  localparam int TSF_CLKS_PER_US = 100; // 100 MHz clk
  localparam int TSF_DIV_WIDTH   = $clog2(TSF_CLKS_PER_US);

  localparam logic [REG_DATA_WIDTH-1:0] XPU_HW_VERSION = 32'h0b1c_0a05;

  // register word indices
  localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_LOAD_LO  = 6'd2;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_LOAD_HI  = 6'd3;  // bit 31 rising edge loads
  localparam logic [REG_ADDR_WIDTH-1:0] REG_BAND_CHANNEL = 6'd4;  // 19:16 band, 15:0 channel
  localparam logic [REG_ADDR_WIDTH-1:0] REG_MAC_LO       = 6'd30;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_MAC_HI       = 6'd31; // 15:0 only
  localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_RD_LO    = 6'd58;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_RD_HI    = 6'd59;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_ADDR2_RD     = 6'd62;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_VERSION      = 6'd63;

  // byte offsets inside the received mac header
  localparam int HDR_FC_OFS    = 0;
  localparam int HDR_ADDR1_OFS = 4;
  localparam int HDR_ADDR2_OFS = 10;
  localparam int HDR_ADDR3_OFS = 16;
  localparam int HDR_SC_OFS    = 22;
  localparam int HDR_LEN       = 24; // bytes up to and incl. sequence control

  typedef struct packed {
    logic                      en;
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [REG_DATA_WIDTH-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic        strobe;
    logic [15:0] idx;  // byte count from demod
    logic [7:0]  data;
  } rx_byte_t;

  // frame control and duration over the first four header bytes
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [15:0] duration;
      logic        order;
      logic        protected_frame;
      logic        more_data;
      logic        power_manage;
      logic        retry;
      logic        more_frag;
      logic        from_ds;
      logic        to_ds;
      logic [3:0]  subtype;
      logic [1:0]  ftype;
      logic [1:0]  version;
    } f;
  } fc_di_u;

  typedef struct packed {
    fc_di_u                    fc;
    logic [MAC_ADDR_WIDTH-1:0] addr1;
    logic [MAC_ADDR_WIDTH-1:0] addr2;
    logic [MAC_ADDR_WIDTH-1:0] addr3;
    logic [15:0]               sc;
    logic                      fc_valid;
    logic                      addr1_valid;
    logic                      addr2_valid;
    logic                      addr3_valid;
    logic                      sc_valid;
  } rx_hdr_t;

  typedef struct packed {
    logic                       load;
    logic [TSF_TIMER_WIDTH-1:0] val;
  } tsf_load_t;

endpackage

//--- hw/xpu_regs.sv
// xpu configuration registers with tsf load trigger and read-back mux
`timescale 1ns/1ps

module xpu_regs import xpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  reg_wr_t                    reg_wr_i,
  input  logic                       rd_en_i,
  input  logic [REG_ADDR_WIDTH-1:0]  rd_addr_i,
  input  logic [TSF_TIMER_WIDTH-1:0] tsf_runtime_val_i,
  input  rx_hdr_t                    rx_hdr_i,
  output logic [REG_DATA_WIDTH-1:0]  rd_data_o,
  output logic                       rd_valid_o,
  output tsf_load_t                  tsf_load_o,
  output logic [3:0]                 band_o,
  output logic [15:0]                channel_o,
  output logic [MAC_ADDR_WIDTH-1:0]  mac_addr_o
);

  logic [REG_DATA_WIDTH-1:0] tsf_load_lo_q;   // reg 2
  logic [REG_DATA_WIDTH-1:0] tsf_load_hi_q;   // reg 3
  logic [REG_DATA_WIDTH-1:0] band_channel_q;  // reg 4
  logic [REG_DATA_WIDTH-1:0] mac_lo_q;        // reg 30
  logic [REG_DATA_WIDTH-1:0] mac_hi_q;        // reg 31
  logic                      tsf_load_q;
  logic                      tsf_load_trig;
  logic [REG_DATA_WIDTH-1:0] addr2_rd;
  logic [REG_DATA_WIDTH-1:0] rd_mux;

  // load only on 0 -> 1 of the stored msb
  assign tsf_load_trig = reg_wr_i.en && (reg_wr_i.addr == REG_TSF_LOAD_HI) &&
                         reg_wr_i.data[REG_DATA_WIDTH-1] &&
                         !tsf_load_hi_q[REG_DATA_WIDTH-1];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tsf_load_lo_q  <= '0;
      tsf_load_hi_q  <= '0;
      band_channel_q <= '0;
      mac_lo_q       <= '0;
      mac_hi_q       <= '0;
      tsf_load_q     <= 1'b0;
    end else begin
      tsf_load_q <= tsf_load_trig;
      if (reg_wr_i.en) begin
        case (reg_wr_i.addr)
          REG_TSF_LOAD_LO:  tsf_load_lo_q  <= reg_wr_i.data;
          REG_TSF_LOAD_HI:  tsf_load_hi_q  <= reg_wr_i.data;
          REG_BAND_CHANNEL: band_channel_q <= reg_wr_i.data;
          REG_MAC_LO:       mac_lo_q       <= reg_wr_i.data;
          REG_MAC_HI:       mac_hi_q       <= reg_wr_i.data;
          default: ;
        endcase
      end
    end
  end

  // high word sits on top, so bit 31 of reg 3 is also tsf bit 63
  assign tsf_load_o = '{load: tsf_load_q,
                        val:  {tsf_load_hi_q[TSF_TIMER_WIDTH-REG_DATA_WIDTH-1:0], tsf_load_lo_q}};

  assign band_o     = band_channel_q[19:16];
  assign channel_o  = band_channel_q[15:0];
  assign mac_addr_o = {mac_hi_q[MAC_ADDR_WIDTH-REG_DATA_WIDTH-1:0], mac_lo_q};

  // byte reversed so software can tell the on-air byte order
  assign addr2_rd = {rx_hdr_i.addr2[23:16], rx_hdr_i.addr2[31:24],
                     rx_hdr_i.addr2[39:32], rx_hdr_i.addr2[47:40]};

  always_comb begin
    case (rd_addr_i)
      REG_TSF_LOAD_LO:  rd_mux = tsf_load_lo_q;
      REG_TSF_LOAD_HI:  rd_mux = tsf_load_hi_q;
      REG_BAND_CHANNEL: rd_mux = band_channel_q;
      REG_MAC_LO:       rd_mux = mac_lo_q;
      REG_MAC_HI:       rd_mux = mac_hi_q;
      REG_TSF_RD_LO:    rd_mux = tsf_runtime_val_i[REG_DATA_WIDTH-1:0];
      REG_TSF_RD_HI:    rd_mux = tsf_runtime_val_i[TSF_TIMER_WIDTH-1:REG_DATA_WIDTH];
      REG_ADDR2_RD:     rd_mux = addr2_rd;
      REG_VERSION:      rd_mux = XPU_HW_VERSION;
      default:          rd_mux = '0; // unmapped
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= rd_mux;
    end
  end

endmodule

//--- project.f
hw/xpu_pkg.sv
hw/xpu_regs.sv
hw/tsf_timer.sv
hw/rx_header_parse.sv
hw/activity_leds.sv
hw/xpu.sv
sim/xpu_properties.sv
sim/xpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the xpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module xpu_tb \
  -f project.f

# a failed check ends in $fatal, so the exit status carries the result
./obj_dir/Vxpu_tb

//--- sim/xpu_properties.sv
// xpu timing checks for the tsf pulse, read latency and header flag clearing
`timescale 1ns/1ps

module xpu_properties import xpu_pkg::*; (
  input logic    clk,
  input logic    rst_n_i,
  input logic    tsf_pulse_1m_o,
  input logic    rd_en_i,
  input logic    rd_valid_o,
  input logic    pkt_header_valid_strobe_i,
  input rx_hdr_t rx_hdr_o
);

  logic any_valid;

  assign any_valid = rx_hdr_o.fc_valid | rx_hdr_o.addr1_valid | rx_hdr_o.addr2_valid |
                     rx_hdr_o.addr3_valid | rx_hdr_o.sc_valid;

  tsf_pulse_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    tsf_pulse_1m_o |=> !tsf_pulse_1m_o)
    else $error("tsf_pulse_1m_o stayed high for more than one cycle");

  // read data comes back exactly one cycle after the request
  rd_valid_after_rd_en: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_en_i |=> rd_valid_o)
    else $error("rd_valid_o missing one cycle after rd_en_i");

  rd_valid_only_after_rd_en: assert property (@(posedge clk) disable iff (!rst_n_i)
    !rd_en_i |=> !rd_valid_o)
    else $error("rd_valid_o high without a read one cycle before");

  valid_clear_after_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
    pkt_header_valid_strobe_i |=> !any_valid)
    else $error("header valid bits still set after the header strobe");

endmodule

bind xpu xpu_properties props (
  .clk                       (clk),
  .rst_n_i                   (rst_n_i),
  .tsf_pulse_1m_o            (tsf_pulse_1m_o),
  .rd_en_i                   (rd_en_i),
  .rd_valid_o                (rd_valid_o),
  .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
  .rx_hdr_o                  (rx_hdr_o)
);

//--- sim/xpu_tb.sv
// xpu testbench with random register, header, tsf and led traffic against a model
`timescale 1ns/1ps

module xpu_tb import xpu_pkg::*; ();

  localparam int WAIT_LIMIT = 4 * TSF_CLKS_PER_US; // cycles before a wait gives up
  localparam int NUM_FRAMES = 12;

  logic                       clk = 1'b0;
  logic                       rst_n_i;
  reg_wr_t                    reg_wr_i;
  logic                       rd_en_i;
  logic [REG_ADDR_WIDTH-1:0]  rd_addr_i;
  logic [REG_DATA_WIDTH-1:0]  rd_data_o;
  logic                       rd_valid_o;
  rx_byte_t                   rx_byte_i;
  logic                       pkt_header_valid_i;
  logic                       pkt_header_valid_strobe_i;
  logic                       demod_is_ongoing_i;
  logic                       phy_tx_started_i;
  rx_hdr_t                    rx_hdr_o;
  logic                       pkt_for_me_o;
  logic [TSF_TIMER_WIDTH-1:0] tsf_runtime_val_o;
  logic                       tsf_pulse_1m_o;
  logic [3:0]                 band_o;
  logic [15:0]                channel_o;
  logic [MAC_ADDR_WIDTH-1:0]  mac_addr_o;
  logic [2:0]                 leds_o;

  int         led_edges [3]; // rising edges seen per led event
  logic [2:0] ev_now;
  logic [2:0] ev_prev;

  xpu dut (.*);

  always #20 clk = ~clk;

  // led model keeps one edge counter per event
  always @(posedge clk) begin
    ev_now = {phy_tx_started_i, pkt_header_valid_strobe_i & pkt_header_valid_i,
              demod_is_ongoing_i};
    for (int i = 0; i < 3; i++) begin
      if (!rst_n_i) led_edges[i] = 0;
      else if (ev_now[i] && !ev_prev[i]) led_edges[i]++;
    end
    ev_prev = rst_n_i ? ev_now : 3'b000;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic check_word(input string name, input logic [REG_DATA_WIDTH-1:0] act, exp);
    if (act !== exp)
      report_failure($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic act, exp);
    if (act !== exp)
      report_failure($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, act));
  endtask

  task automatic check_tsf(input string name, input logic [TSF_TIMER_WIDTH-1:0] act, exp);
    if (act !== exp)
      report_failure($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_hdr(input string name, input rx_hdr_t act, exp);
    if (act !== exp)
      report_failure($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic step();
    @(posedge clk);
    #2; // inputs change and outputs are sampled here
  endtask

  task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                           input logic [REG_DATA_WIDTH-1:0] data);
    reg_wr_i = '{en: 1'b1, addr: addr, data: data};
    step();
    reg_wr_i.en = 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                          output logic [REG_DATA_WIDTH-1:0] data);
    rd_en_i   = 1'b1;
    rd_addr_i = addr;
    step();
    rd_en_i = 1'b0;
    check_bit("rd_valid_o", rd_valid_o, 1'b1);
    data = rd_data_o;
  endtask

  task automatic wait_pulse(output int cycles);
    cycles = 0;
    do begin
      step();
      cycles++;
      if (cycles > WAIT_LIMIT) report_failure("tsf_pulse_1m_o never came within the wait limit");
    end while (!tsf_pulse_1m_o);
  endtask

  // random header in 802.11 byte order with the low byte of each field first
  task automatic send_frame(input logic [MAC_ADDR_WIDTH-1:0] own_mac, input bit to_me,
                            output rx_hdr_t exp);
    logic [7:0] frame [HDR_LEN];
    exp = '0;
    exp.fc.f.ftype    = 2'($urandom_range(0, 2));
    exp.fc.f.subtype  = 4'($urandom);
    exp.fc.f.duration = 16'($urandom);
    {exp.fc.f.order, exp.fc.f.protected_frame, exp.fc.f.more_data, exp.fc.f.power_manage,
     exp.fc.f.retry, exp.fc.f.more_frag, exp.fc.f.from_ds, exp.fc.f.to_ds} = 8'($urandom);
    exp.addr1 = to_me ? own_mac : 48'({$urandom, $urandom});
    exp.addr2 = 48'({$urandom, $urandom});
    exp.addr3 = 48'({$urandom, $urandom});
    exp.sc    = 16'($urandom);
    frame[0] = {exp.fc.f.subtype, exp.fc.f.ftype, exp.fc.f.version};
    frame[1] = {exp.fc.f.order, exp.fc.f.protected_frame, exp.fc.f.more_data,
                exp.fc.f.power_manage, exp.fc.f.retry, exp.fc.f.more_frag,
                exp.fc.f.from_ds, exp.fc.f.to_ds};
    frame[2] = exp.fc.f.duration[7:0];
    frame[3] = exp.fc.f.duration[15:8];
    for (int i = 0; i < 6; i++) begin
      frame[HDR_ADDR1_OFS+i] = exp.addr1[8*i +: 8];
      frame[HDR_ADDR2_OFS+i] = exp.addr2[8*i +: 8];
      frame[HDR_ADDR3_OFS+i] = exp.addr3[8*i +: 8];
    end
    frame[HDR_SC_OFS]   = exp.sc[7:0];
    frame[HDR_SC_OFS+1] = exp.sc[15:8];
    for (int k = 0; k < HDR_LEN; k++) begin
      rx_byte_i = '{strobe: 1'b1, idx: 16'(k), data: frame[k]};
      step();
      rx_byte_i.strobe = 1'b0;
      rx_byte_i.data   = 8'($urandom); // idle junk
      check_bit("rx_hdr_o.fc_valid", rx_hdr_o.fc_valid, k >= HDR_ADDR1_OFS - 1);
      check_bit("rx_hdr_o.addr1_valid", rx_hdr_o.addr1_valid, k >= HDR_ADDR2_OFS - 1);
      check_bit("rx_hdr_o.addr2_valid", rx_hdr_o.addr2_valid, k >= HDR_ADDR3_OFS - 1);
      check_bit("rx_hdr_o.addr3_valid", rx_hdr_o.addr3_valid, k >= HDR_SC_OFS - 1);
      check_bit("rx_hdr_o.sc_valid", rx_hdr_o.sc_valid, k >= HDR_LEN - 1);
      check_bit("pkt_for_me_o", pkt_for_me_o,
                (k >= HDR_ADDR2_OFS - 1) && (exp.addr1 == own_mac));
      repeat ($urandom_range(0, 3)) step();
    end
    {exp.fc_valid, exp.addr1_valid, exp.addr2_valid, exp.addr3_valid, exp.sc_valid} = '1;
  endtask

  initial begin
    rx_hdr_t                    exp_hdr;
    logic [REG_DATA_WIDTH-1:0]  rd_word;
    logic [REG_DATA_WIDTH-1:0]  rd_hi;
    logic [REG_DATA_WIDTH-1:0]  band_ch;
    logic [REG_DATA_WIDTH-1:0]  mac_lo;
    logic [REG_DATA_WIDTH-1:0]  mac_hi;
    logic [REG_DATA_WIDTH-1:0]  load_lo;
    logic [REG_DATA_WIDTH-1:0]  load_hi;
    logic [REG_DATA_WIDTH-1:0]  exp_addr2_rd;
    logic [TSF_TIMER_WIDTH-1:0] load_val;
    logic [MAC_ADDR_WIDTH-1:0]  own_mac;
    logic [REG_ADDR_WIDTH-1:0]  unmapped;
    int                         cycles;
    int                         n_pulses;
    void'($urandom(32'h4b0ab2ec));
    rst_n_i                   = 1'b0;
    reg_wr_i                  = '0;
    rd_en_i                   = 1'b0;
    rd_addr_i                 = '0;
    rx_byte_i                 = '0;
    pkt_header_valid_i        = 1'b0;
    pkt_header_valid_strobe_i = 1'b0;
    demod_is_ongoing_i        = 1'b0;
    phy_tx_started_i          = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n_i = 1'b1;

    check_word("leds_o", {29'h0, leds_o}, 32'h0);
    check_bit("pkt_for_me_o", pkt_for_me_o, 1'b0);
    check_bit("rd_valid_o", rd_valid_o, 1'b0);
    check_bit("rx_hdr_o valid bits", rx_hdr_o.fc_valid | rx_hdr_o.addr1_valid |
              rx_hdr_o.addr2_valid | rx_hdr_o.addr3_valid | rx_hdr_o.sc_valid, 1'b0);
    check_tsf("tsf_runtime_val_o", tsf_runtime_val_o, '0);

    // configuration registers
    band_ch = {12'h0, 4'($urandom), 16'($urandom)};
    mac_lo  = $urandom;
    mac_hi  = $urandom; // only 15:0 reach the address
    write_reg(REG_BAND_CHANNEL, band_ch);
    check_word("band_o", {28'h0, band_o}, {28'h0, band_ch[19:16]});
    check_word("channel_o", {16'h0, channel_o}, {16'h0, band_ch[15:0]});
    write_reg(REG_MAC_LO, mac_lo);
    check_word("mac_addr_o[31:0]", mac_addr_o[31:0], mac_lo);
    write_reg(REG_MAC_HI, mac_hi);
    check_word("mac_addr_o[47:32]", {16'h0, mac_addr_o[47:32]}, {16'h0, mac_hi[15:0]});
    own_mac = {mac_hi[15:0], mac_lo};
    read_reg(REG_BAND_CHANNEL, rd_word);
    check_word("rd_data_o reg 4", rd_word, band_ch);
    read_reg(REG_MAC_LO, rd_word);
    check_word("rd_data_o reg 30", rd_word, mac_lo);
    read_reg(REG_MAC_HI, rd_word);
    check_word("rd_data_o reg 31", rd_word, mac_hi);
    read_reg(REG_VERSION, rd_word);
    check_word("rd_data_o reg 63", rd_word, XPU_HW_VERSION);
    unmapped = 6'($urandom_range(5, 29));
    read_reg(unmapped, rd_word);
    check_word("rd_data_o unmapped", rd_word, 32'h0);

    // header frames with every other one addressed to us
    for (int f = 0; f < NUM_FRAMES; f++) begin
      send_frame(own_mac, f[0] == 1'b0, exp_hdr);
      check_hdr("rx_hdr_o", rx_hdr_o, exp_hdr);
      check_bit("pkt_for_me_o", pkt_for_me_o, exp_hdr.addr1 == own_mac);
      for (int b = 0; b < 4; b++) begin
        exp_addr2_rd[8*(3-b) +: 8] = exp_hdr.addr2[8*(b+2) +: 8]; // on-air byte 2 on top
      end
      read_reg(REG_ADDR2_RD, rd_word);
      check_word("rd_data_o reg 62", rd_word, exp_addr2_rd);
      pkt_header_valid_i        = 1'($urandom);
      pkt_header_valid_strobe_i = 1'b1;
      step();
      pkt_header_valid_strobe_i = 1'b0;
      pkt_header_valid_i        = 1'b0;
      check_bit("rx_hdr_o valid bits", rx_hdr_o.fc_valid | rx_hdr_o.addr1_valid |
                rx_hdr_o.addr2_valid | rx_hdr_o.addr3_valid | rx_hdr_o.sc_valid, 1'b0);
      check_bit("pkt_for_me_o", pkt_for_me_o, 1'b0);
    end

    // msb of reg 3 low first so the second write is a rising edge
    repeat (2) begin
      load_lo = $urandom;
      load_hi = $urandom;
      write_reg(REG_TSF_LOAD_HI, {1'b0, load_hi[30:0]});
      write_reg(REG_TSF_LOAD_LO, load_lo);
      write_reg(REG_TSF_LOAD_HI, {1'b1, load_hi[30:0]});
      load_val = {1'b1, load_hi[30:0], load_lo};
      step(); // counter takes the value here
      check_tsf("tsf_runtime_val_o", tsf_runtime_val_o, load_val);
      n_pulses = $urandom_range(2, 4);
      for (int p = 1; p <= n_pulses; p++) begin
        wait_pulse(cycles);
        check_word("tsf_pulse_1m_o spacing", 32'(cycles), 32'(TSF_CLKS_PER_US));
        check_tsf("tsf_runtime_val_o", tsf_runtime_val_o, load_val + 64'(p));
      end
      read_reg(REG_TSF_RD_LO, rd_word);
      read_reg(REG_TSF_RD_HI, rd_hi);
      check_tsf("rd_data_o tsf", {rd_hi, rd_word}, load_val + 64'(n_pulses));
    end

    // led activity
    repeat (300) begin
      if ($urandom_range(0, 4) == 0) demod_is_ongoing_i = ~demod_is_ongoing_i;
      pkt_header_valid_i        = 1'($urandom);
      pkt_header_valid_strobe_i = ($urandom_range(0, 3) == 0);
      phy_tx_started_i          = ($urandom_range(0, 7) == 0);
      step();
    end
    demod_is_ongoing_i        = 1'b0;
    pkt_header_valid_i        = 1'b0;
    pkt_header_valid_strobe_i = 1'b0;
    phy_tx_started_i          = 1'b0;
    repeat (2) step();
    for (int i = 0; i < 3; i++) begin
      check_bit($sformatf("leds_o[%0d]", i), leds_o[i], 1'(led_edges[i] % 2));
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule
